//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_flash_subsys
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
rtl/flash_pkg.sv
rtl/bus_port.sv
rtl/flash_req_fifo.sv
rtl/flash_controller.sv
rtl/flash_subsys_top.sv
sim/flash_model.sv
sim/tb_flash_subsys.sv

//--- rtl/bus_port.sv
module bus_port import flash_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        read,
    input  logic        write,
    input  logic [19:0] addr,
    input  logic [31:0] wdata,
    input  logic        full,
    output logic        stall,
    output logic        push,
    output flash_req_t  req,
    input  flash_rsp_t  ctrl_rsp,
    output flash_rsp_t  rsp
);

    logic       pending_q;  // registered request waiting for the FIFO
    flash_req_t req_q;
    logic       accept;
    logic       rsp_valid_q;
    logic [31:0] rsp_data_q;

    assign stall  = full;
    assign accept = (read | write) & ~full;  // strobes during stall are dropped

    // a request sampled while the FIFO filled up waits here until a slot frees
    assign push = pending_q & ~full;
    assign req  = req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (accept) begin
            pending_q <= 1'b1;
        end else if (push) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.op    <= read ? OP_READ : OP_WRITE;  // read wins
            req_q.addr  <= addr;
            req_q.wdata <= wdata;
        end
    end

    // response path, one register stage back to the bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= ctrl_rsp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_rsp.valid) begin
            rsp_data_q <= ctrl_rsp.rdata;
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.rdata = rsp_data_q;

endmodule

//--- rtl/flash_controller.sv
module flash_controller import flash_pkg::*; #(
    parameter int WAIT_CYCLES = 4  // cycles per half-word phase, at least 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        empty,
    input  flash_req_t  head,
    output logic        pop,
    output flash_rsp_t  rsp,
    output flash_pins_t pins,
    input  logic [15:0] dq_in
);

    localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

    localparam flash_pins_t PINS_IDLE = '{
        ce_n:   1'b1,
        we_n:   1'b1,
        oe_n:   1'b1,
        addr:   '0,
        dq_out: '0,
        dq_oe:  1'b0
    };

    ctrl_state_e state;
    logic [CNT_W-1:0] cnt;        // cycle within the current phase
    flash_op_e   cur_op;
    logic [19:0] cur_addr;
    logic [15:0] cur_wdata;       // upper bus half is not written
    logic [31:0] rdata_q;
    flash_pins_t pins_q;
    logic        phase_last;
    logic        we_end;

    // pins for the start of a phase
    function automatic flash_pins_t phase_pins(input flash_op_e   op,
                                               input logic [21:0] a,
                                               input logic [15:0] d);
        flash_pins_t p;
        p.ce_n   = 1'b0;
        p.we_n   = (op == OP_READ);
        p.oe_n   = (op == OP_WRITE);
        p.addr   = a;
        p.dq_out = d;
        p.dq_oe  = (op == OP_WRITE);
        return p;
    endfunction

    assign phase_last = (cnt == CNT_W'(WAIT_CYCLES - 1));
    assign we_end     = (cnt == CNT_W'(WAIT_CYCLES - 2));

    assign pop  = (state == ST_IDLE) && !empty;
    assign pins = pins_q;

    // response is valid during ST_DONE of a read only
    assign rsp.valid = (state == ST_DONE) && (cur_op == OP_READ);
    assign rsp.rdata = rdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_RESET;
            cnt    <= '0;
            cur_op <= OP_WRITE;  // keeps the command cycle from answering
            pins_q <= PINS_IDLE;
        end else begin
            unique case (state)
                ST_RESET: begin
                    // chip recovery, then one command phase at address 0
                    cnt <= cnt + 1'b1;
                    if (phase_last) begin
                        cnt    <= '0;
                        cur_op <= OP_WRITE;
                        pins_q <= phase_pins(OP_WRITE, 22'd0, FLASH_CMD_READ_ARRAY);
                        state  <= ST_HI;
                    end
                end

                ST_IDLE: begin
                    if (!empty) begin
                        cur_op <= head.op;
                        cnt    <= '0;
                        pins_q <= phase_pins(head.op, {head.addr, 2'b00},
                                             head.wdata[15:0]);
                        state  <= ST_LO;
                    end
                end

                ST_LO: begin
                    cnt <= cnt + 1'b1;
                    if (we_end && cur_op == OP_WRITE) begin
                        // rising we_n latches the half-word in the chip
                        pins_q.we_n  <= 1'b1;
                        pins_q.dq_oe <= 1'b0;
                    end
                    if (phase_last) begin
                        cnt    <= '0;
                        pins_q <= phase_pins(cur_op, {cur_addr, 2'b10}, cur_wdata);
                        state  <= ST_HI;
                    end
                end

                ST_HI: begin
                    cnt <= cnt + 1'b1;
                    if (we_end && cur_op == OP_WRITE) begin
                        pins_q.we_n  <= 1'b1;
                        pins_q.dq_oe <= 1'b0;
                    end
                    if (phase_last) begin
                        cnt          <= '0;
                        pins_q.ce_n  <= 1'b1;
                        pins_q.we_n  <= 1'b1;
                        pins_q.oe_n  <= 1'b1;
                        pins_q.dq_oe <= 1'b0;
                        state        <= ST_DONE;
                    end
                end

                ST_DONE: begin
                    state <= ST_IDLE;
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload and read data, no reset needed
    always_ff @(posedge clk) begin
        if (pop) begin
            cur_addr  <= head.addr;
            cur_wdata <= head.wdata[15:0];
        end
        if (phase_last && cur_op == OP_READ) begin
            if (state == ST_LO) begin
                rdata_q[15:0] <= dq_in;   // low half first
            end
            if (state == ST_HI) begin
                rdata_q[31:16] <= dq_in;
            end
        end
    end

    // chip must never see a read and a write strobe at once
    a_oe_we_excl: assert property (@(posedge clk) disable iff (rst)
        !(!pins_q.oe_n && !pins_q.we_n));

    a_dq_oe_we: assert property (@(posedge clk) disable iff (rst)
        pins_q.dq_oe |-> !pins_q.we_n);

endmodule

//--- rtl/flash_pkg.sv
package flash_pkg;

    // bus side operation, read has priority when both strobes arrive together
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } flash_op_e;

    // one queued bus access
    typedef struct packed {
        flash_op_e   op;
        logic [19:0] addr;   // 32-bit word address
        logic [31:0] wdata;  // only [15:0] reaches the chip
    } flash_req_t;

    // read data returned to the bus
    typedef struct packed {
        logic        valid;  // one-cycle pulse
        logic [31:0] rdata;
    } flash_rsp_t;

    // chip side pins, data bus split instead of tri-state
    typedef struct packed {
        logic        ce_n;
        logic        we_n;
        logic        oe_n;
        logic [21:0] addr;   // chip byte address
        logic [15:0] dq_out;
        logic        dq_oe;
    } flash_pins_t;

    // access sequencer states
    typedef enum logic [2:0] {
        ST_RESET,  // recovery wait, then read-array command
        ST_IDLE,
        ST_LO,     // half-word at 4*A
        ST_HI,     // half-word at 4*A+2
        ST_DONE
    } ctrl_state_e;

    // puts the chip back into read-array mode
    localparam logic [15:0] FLASH_CMD_READ_ARRAY = 16'h00FF;

endpackage

//--- rtl/flash_req_fifo.sv
module flash_req_fifo import flash_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  flash_req_t push_req,
    input  logic       pop,
    output flash_req_t head,
    output logic       full,
    output logic       empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    flash_req_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];  // show-ahead

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // wrap explicitly, DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

//--- rtl/flash_subsys_top.sv
module flash_subsys_top import flash_pkg::*; #(
    parameter int WAIT_CYCLES = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        read,
    input  logic        write,
    input  logic [19:0] addr,
    input  logic [31:0] wdata,
    output logic        stall,
    output flash_rsp_t  rsp,
    output flash_pins_t pins,
    input  logic [15:0] dq_in
);

    logic       push;
    logic       pop;
    logic       full;
    logic       empty;
    flash_req_t push_req;
    flash_req_t head;
    flash_rsp_t ctrl_rsp;

    bus_port u_bus_port (
        .clk      (clk),
        .rst      (rst),
        .read     (read),
        .write    (write),
        .addr     (addr),
        .wdata    (wdata),
        .full     (full),
        .stall    (stall),
        .push     (push),
        .req      (push_req),
        .ctrl_rsp (ctrl_rsp),
        .rsp      (rsp)
    );

    flash_req_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_req (push_req),
        .pop      (pop),
        .head     (head),
        .full     (full),
        .empty    (empty)
    );

    flash_controller #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .empty (empty),
        .head  (head),
        .pop   (pop),
        .rsp   (ctrl_rsp),
        .pins  (pins),
        .dq_in (dq_in)
    );

endmodule

//--- sim/flash_model.sv
module flash_model import flash_pkg::*; (
    input  logic        clk,
    input  flash_pins_t pins,
    output logic [15:0] dq,         // read data towards the controller
    input  logic        load,       // testbench preload port
    input  logic [9:0]  load_idx,
    input  logic [15:0] load_data,
    input  logic [9:0]  peek_idx,   // testbench read-back port
    output logic [15:0] peek_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] mem [1024];  // half-words, chip byte address bits [10:1]
    logic        we_n_q;
    logic [9:0]  idx;

    assign idx       = pins.addr[10:1];
    assign dq        = (!pins.ce_n && !pins.oe_n) ? mem[idx] : 16'hFFFF;
    assign peek_data = mem[peek_idx];

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] <= 16'hFFFF;  // erased
        end
        we_n_q <= 1'b1;
    end

    always @(posedge clk) begin
        we_n_q <= pins.we_n;
        // rising edge of we_n with the chip selected latches the data
        if (!we_n_q && pins.we_n && !pins.ce_n) begin
            mem[idx] <= pins.dq_out;
        end
        if (load) begin
            mem[load_idx] <= load_data;
        end
    end

endmodule

//--- sim/tb_flash_subsys.sv
module tb_flash_subsys import flash_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_CYCLES = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int N_OPS       = 40;  // bus operations issued over all tests
    localparam int MAX_CYCLES  = N_OPS * (2 * WAIT_CYCLES + 6) + 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        read;
    logic        write;
    logic [19:0] addr;
    logic [31:0] wdata;
    logic        stall;
    flash_rsp_t  rsp;
    flash_pins_t pins;
    logic [15:0] dq_in;
    logic        load;
    logic [9:0]  load_idx;
    logic [15:0] load_data;
    logic [9:0]  peek_idx;
    logic [15:0] peek_data;

    logic [15:0] ref_mem [1024];  // expected chip contents
    logic [31:0] exp_q [$];       // expected read data, request order
    int          rsp_errors   = 0;
    int          half_errors  = 0;
    int          other_errors = 0;
    int          cycles       = 0;
    logic        stall_seen   = 1'b0;

    flash_subsys_top #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) UUT (
        .clk   (clk),
        .rst   (rst),
        .read  (read),
        .write (write),
        .addr  (addr),
        .wdata (wdata),
        .stall (stall),
        .rsp   (rsp),
        .pins  (pins),
        .dq_in (dq_in)
    );

    flash_model u_flash (
        .clk       (clk),
        .pins      (pins),
        .dq        (dq_in),
        .load      (load),
        .load_idx  (load_idx),
        .load_data (load_data),
        .peek_idx  (peek_idx),
        .peek_data (peek_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: DUT did not finish");
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_rsp(input flash_rsp_t got, input logic [31:0] exp, input string what);
        if (got.rdata !== exp) begin
            $display("** Error at %0t: %s got %h, expected %h", $time, what, got.rdata, exp);
            rsp_errors++;
        end
    endtask

    task automatic check_half(input logic [15:0] got, input logic [15:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
            half_errors++;
        end
    endtask

    // responses come back one cycle wide, sampled mid-cycle
    always @(negedge clk) begin
        if (stall) begin
            stall_seen = 1'b1;
        end
        if (!rst && rsp.valid) begin
            if (exp_q.size() == 0) begin
                $display("read response at %0t with no read outstanding", $time);
                other_errors++;
            end else begin
                check_rsp(rsp, exp_q.pop_front(), "read data");
            end
        end
    end

    function automatic logic [9:0] lo_idx(input logic [19:0] a);
        return 10'({a, 1'b0});  // byte address 4*A
    endfunction

    function automatic logic [9:0] hi_idx(input logic [19:0] a);
        return 10'({a, 1'b1});  // byte address 4*A+2
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_write(input logic [19:0] a, input logic [31:0] d);
        while (stall) next_cycle();
        write = 1'b1;
        addr  = a;
        wdata = d;
        next_cycle();
        write = 1'b0;
        ref_mem[lo_idx(a)] = d[15:0];  // low half lands on both half-words
        ref_mem[hi_idx(a)] = d[15:0];
    endtask

    task automatic issue_read(input logic [19:0] a);
        while (stall) next_cycle();
        read = 1'b1;
        addr = a;
        next_cycle();
        read = 1'b0;
        exp_q.push_back({ref_mem[hi_idx(a)], ref_mem[lo_idx(a)]});
    endtask

    task automatic drain();
        while (exp_q.size() != 0) next_cycle();
    endtask

    task automatic preload(input logic [19:0] a, input logic [15:0] lo, input logic [15:0] hi);
        load      = 1'b1;
        load_idx  = lo_idx(a);
        load_data = lo;
        next_cycle();
        load_idx  = hi_idx(a);
        load_data = hi;
        next_cycle();
        load = 1'b0;
        ref_mem[lo_idx(a)] = lo;
        ref_mem[hi_idx(a)] = hi;
    endtask

    task automatic check_model_word(input logic [19:0] a);
        peek_idx = lo_idx(a);
        #1 check_half(peek_data, ref_mem[lo_idx(a)], "model low half-word");
        peek_idx = hi_idx(a);
        #1 check_half(peek_data, ref_mem[hi_idx(a)], "model high half-word");
    endtask

    task automatic check_reset_state();
        if (pins.ce_n !== 1'b1 || pins.we_n !== 1'b1 || pins.oe_n !== 1'b1
            || pins.dq_oe !== 1'b0 || rsp.valid !== 1'b0 || stall !== 1'b0) begin
            $display("outputs not in their idle state after reset at %0t", $time);
            other_errors++;
        end
    endtask

    task automatic test_reset_cmd();
        issue_read(20'd0);
        drain();
        check_model_word(20'd0);
        if (pins.ce_n !== 1'b1 || pins.we_n !== 1'b1 || pins.oe_n !== 1'b1) begin
            $display("chip enables not all high at idle at %0t", $time);
            other_errors++;
        end
    endtask

    task automatic test_write_read();
        logic [19:0] a;
        for (int i = 0; i < 4; i++) begin
            a = 20'($urandom_range(255, 1));
            issue_write(a, $urandom);
            issue_read(a);
            drain();
            check_model_word(a);
        end
    endtask

    task automatic test_preloaded_read();
        logic [19:0] a;
        for (int i = 0; i < 4; i++) begin
            a = 20'($urandom_range(255, 1));
            preload(a, 16'($urandom), 16'($urandom));
            issue_read(a);
            drain();
        end
    endtask

    task automatic test_back_pressure();
        logic [19:0] a;
        logic [19:0] written [$];
        stall_seen = 1'b0;
        for (int i = 0; i < 24; i++) begin
            a = 20'($urandom_range(255, 1));
            if ($urandom_range(1, 0) == 1) begin
                issue_write(a, $urandom);
                written.push_back(a);
            end else begin
                issue_read(a);
            end
        end
        issue_read(a);  // answers only after every earlier write
        drain();
        if (!stall_seen) begin
            $display("stall never rose while requests were queued");
            other_errors++;
        end
        foreach (written[i]) begin
            check_model_word(written[i]);
        end
    endtask

    task automatic test_collision();
        logic [19:0] a;
        a = 20'($urandom_range(255, 1));
        while (stall) next_cycle();
        read  = 1'b1;
        write = 1'b1;
        addr  = a;
        wdata = $urandom;
        next_cycle();
        read  = 1'b0;
        write = 1'b0;
        exp_q.push_back({ref_mem[hi_idx(a)], ref_mem[lo_idx(a)]});  // read only
        drain();
        check_model_word(a);
    endtask

    initial begin
        void'($urandom(32'hf46793f6));
        rst       = 1'b1;
        read      = 1'b0;
        write     = 1'b0;
        addr      = '0;
        wdata     = '0;
        load      = 1'b0;
        load_idx  = '0;
        load_data = '0;
        peek_idx  = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = 16'hFFFF;
        end
        ref_mem[0] = 16'h00FF;  // read-array command written after reset
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        check_reset_state();
        test_reset_cmd();
        test_write_read();
        test_preloaded_read();
        test_back_pressure();
        test_collision();
        $display("errors: %0d response, %0d half-word, %0d other",
                 rsp_errors, half_errors, other_errors);
        if (rsp_errors + half_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
